// File: tb.f
+incdir+source
source/mm_types_pkg.sv
source/stream_beat_pkg.sv
source/axis_skid_buffer.sv
source/pe_control.sv
source/processing_element.sv
source/systolic_array.sv
verif/systolic_array_properties.sv
verif/tb_systolic_array.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_systolic_array
FILELIST  := tb.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
PASS_TEXT := Simulation PASSED

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Status comes from the search for the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_config.svh"

module tb_systolic_array;
  import mm_types_pkg::*;
  import stream_beat_pkg::*;

  localparam int NUM_TESTS    = 6;
  localparam int MAX_K        = 8;
  localparam int MAX_MATS     = 3;
  localparam int MAX_BEATS    = MAX_K * MAX_MATS;
  localparam int MAX_RESULTS  = `PE_ROWS * MAX_MATS;
  localparam int DRAIN_CYCLES = 8;
  localparam operand_t OP_MIN = {1'b1, {(`PE_OPERAND_WIDTH-1){1'b0}}};
  localparam operand_t OP_MAX = ~OP_MIN;

  typedef enum logic [1:0] {
    VAL_FIXED,
    VAL_RANDOM,
    VAL_EXTREME
  } value_mode_t;

  // One table entry with mats matrices streamed back to back
  typedef struct packed {
    int          k;
    int          mats;
    value_mode_t mode;
    logic        back_pressure;
    logic        misalign;
  } test_row_t;

  logic                clk;
  logic                reset;
  operand_beat_t       left_beat [`PE_ROWS];
  logic [`PE_ROWS-1:0] left_valid;
  logic [`PE_ROWS-1:0] left_ready;
  operand_beat_t       top_beat [`PE_COLS];
  logic [`PE_COLS-1:0] top_valid;
  logic [`PE_COLS-1:0] top_ready;
  psum_beat_t          result_beat [`PE_COLS];
  logic [`PE_COLS-1:0] result_valid;
  logic [`PE_COLS-1:0] result_ready;
  logic                err_unaligned;

  test_row_t tests [NUM_TESTS];
  integer    seed;
  int        error_count;
  int        timeout_cycles;

  // Streams and expected words of the running test
  operand_beat_t left_mem [`PE_ROWS][MAX_BEATS];
  operand_beat_t top_mem [`PE_COLS][MAX_BEATS];
  int            stream_len;
  psum_t         exp_data [`PE_COLS][MAX_RESULTS];
  logic          exp_last [`PE_COLS][MAX_RESULTS];
  int            exp_len;
  operand_t      a_mat [`PE_ROWS][MAX_K];
  operand_t      b_mat [MAX_K][`PE_COLS];

  systolic_array i_systolic_array (
    .clk           (clk),
    .reset         (reset),
    .left_beat     (left_beat),
    .left_valid    (left_valid),
    .left_ready    (left_ready),
    .top_beat      (top_beat),
    .top_valid     (top_valid),
    .top_ready     (top_ready),
    .result_beat   (result_beat),
    .result_valid  (result_valid),
    .result_ready  (result_ready),
    .err_unaligned (err_unaligned)
  );

  bind systolic_array systolic_array_properties i_properties (
    .clk           (clk),
    .reset         (reset),
    .left_ready    (left_ready),
    .top_ready     (top_ready),
    .result_beat   (result_beat),
    .result_valid  (result_valid),
    .result_ready  (result_ready),
    .err_unaligned (err_unaligned)
  );

  always #20 clk = ~clk;

  task automatic fill_table();
    tests[0] = '{k: 1, mats: 1, mode: VAL_FIXED, back_pressure: 1'b0, misalign: 1'b0};
    tests[1] = '{k: 4, mats: 1, mode: VAL_RANDOM, back_pressure: 1'b0, misalign: 1'b0};
    tests[2] = '{k: 8, mats: 1, mode: VAL_EXTREME, back_pressure: 1'b0, misalign: 1'b0};
    tests[3] = '{k: 6, mats: 1, mode: VAL_RANDOM, back_pressure: 1'b1, misalign: 1'b0};
    tests[4] = '{k: 4, mats: 3, mode: VAL_RANDOM, back_pressure: 1'b0, misalign: 1'b0};
    // Must stay last since it leaves a word behind in the chain
    tests[5] = '{k: 4, mats: 1, mode: VAL_RANDOM, back_pressure: 1'b0, misalign: 1'b1};
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s actual 0x%0h expected 0x%0h", name, actual, expected);
      error_count++;
    end
  endtask

  // i and j are row and column of the matrix being filled
  function automatic operand_t pick_operand(value_mode_t mode, int i, int j, bit is_b);
    operand_t value;
    case (mode)
      VAL_FIXED: value = operand_t'(i * 4 + j + (is_b ? 2 : 1));
      VAL_EXTREME: begin
        if (is_b) begin
          value = (j == 0 || i % 2 == 0) ? OP_MIN : OP_MAX;
        end else begin
          value = ((i + j) % 3 == 0) ? OP_MAX : OP_MIN;
        end
      end
      default: value = operand_t'($random(seed));
    endcase
    return value;
  endfunction

  // Row of A times column of B wrapping at 32 bits
  function automatic psum_t dot_product(int r, int c, int len);
    int acc;
    acc = 0;
    for (int kk = 0; kk < len; kk++) begin
      acc = acc + int'(a_mat[r][kk]) * int'(b_mat[kk][c]);
    end
    return acc;
  endfunction

  task automatic build_test(input test_row_t t);
    int base;
    int lim;
    int slot;
    stream_len = t.k * t.mats;
    exp_len    = `PE_ROWS * t.mats;
    for (int m = 0; m < t.mats; m++) begin
      base = m * t.k;
      for (int kk = 0; kk < t.k; kk++) begin
        for (int r = 0; r < `PE_ROWS; r++) begin
          a_mat[r][kk] = pick_operand(t.mode, r, kk, 1'b0);
          left_mem[r][base+kk].data = a_mat[r][kk];
          left_mem[r][base+kk].last = (kk == t.k - 1);
        end
        for (int c = 0; c < `PE_COLS; c++) begin
          b_mat[kk][c] = pick_operand(t.mode, kk, c, 1'b1);
          top_mem[c][base+kk].data = b_mat[kk][c];
          top_mem[c][base+kk].last = (kk == t.k - 1);
        end
      end
      // Early last on left row 0 ends its vector one pair short
      if (t.misalign && t.k > 1) begin
        left_mem[0][base+t.k-2].last = 1'b1;
      end
      // Bottom row first and row 0 closes the column
      for (int c = 0; c < `PE_COLS; c++) begin
        for (int r = `PE_ROWS - 1; r >= 0; r--) begin
          slot = m * `PE_ROWS + (`PE_ROWS - 1 - r);
          lim  = (t.misalign && r == 0) ? t.k - 1 : t.k;
          exp_data[c][slot] = dot_product(r, c, lim);
          exp_last[c][slot] = (r == 0);
        end
      end
    end
  endtask

  // Handshakes sampled on the falling edge and inputs driven on the rising edge
  task automatic run_stream(input test_row_t t);
    int                  left_idx [`PE_ROWS];
    int                  top_idx [`PE_COLS];
    int                  res_idx [`PE_COLS];
    logic [`PE_ROWS-1:0] left_fire;
    logic [`PE_COLS-1:0] top_fire;
    logic                done;
    int                  drain;
    for (int r = 0; r < `PE_ROWS; r++) begin
      left_idx[r] = 0;
    end
    for (int c = 0; c < `PE_COLS; c++) begin
      top_idx[c] = 0;
      res_idx[c] = 0;
    end
    drain = 0;
    done  = 1'b0;
    while (drain < DRAIN_CYCLES) begin
      @(negedge clk);
      left_fire = left_valid & left_ready;
      top_fire  = top_valid & top_ready;
      for (int r = 0; r < `PE_ROWS; r++) begin
        if (left_fire[r]) begin
          left_idx[r] = left_idx[r] + 1;
        end
      end
      for (int c = 0; c < `PE_COLS; c++) begin
        if (top_fire[c]) begin
          top_idx[c] = top_idx[c] + 1;
        end
        if (result_valid[c] && result_ready[c]) begin
          if (res_idx[c] < exp_len) begin
            check_value($sformatf("result_beat[%0d].data", c), result_beat[c].data,
                        exp_data[c][res_idx[c]]);
            check_value($sformatf("result_beat[%0d].last", c), 32'(result_beat[c].last),
                        32'(exp_last[c][res_idx[c]]));
            res_idx[c] = res_idx[c] + 1;
          end else begin
            $display("Unexpected extra result word on column %0d", c);
            error_count++;
          end
        end
      end
      done = 1'b1;
      for (int r = 0; r < `PE_ROWS; r++) begin
        if (left_idx[r] < stream_len) done = 1'b0;
      end
      for (int c = 0; c < `PE_COLS; c++) begin
        if (top_idx[c] < stream_len || res_idx[c] < exp_len) done = 1'b0;
      end
      // Quiet period catches repeated words
      if (done) drain++;
      @(posedge clk);
      for (int r = 0; r < `PE_ROWS; r++) begin
        left_valid[r] <= (left_idx[r] < stream_len);
        if (left_idx[r] < stream_len) left_beat[r] <= left_mem[r][left_idx[r]];
      end
      for (int c = 0; c < `PE_COLS; c++) begin
        top_valid[c] <= (top_idx[c] < stream_len);
        if (top_idx[c] < stream_len) top_beat[c] <= top_mem[c][top_idx[c]];
        result_ready[c] <= (t.back_pressure && !done) ? 1'($random(seed)) : 1'b1;
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  // Budget scales with the total stream length of the table
  initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int errors_before;
    int budget;
    clk          = 1'b0;
    reset        = 1'b1;
    seed         = 32'h6cfbcd40;
    error_count  = 0;
    left_valid   = '0;
    top_valid    = '0;
    result_ready = '0;
    for (int r = 0; r < `PE_ROWS; r++) begin
      left_beat[r] = '0;
    end
    for (int c = 0; c < `PE_COLS; c++) begin
      top_beat[c] = '0;
    end
    fill_table();
    budget = 16;
    for (int i = 0; i < NUM_TESTS; i++) begin
      budget = budget + (tests[i].k * tests[i].mats + 20) * 4;
    end
    timeout_cycles = budget;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < NUM_TESTS; i++) begin
      errors_before = error_count;
      build_test(tests[i]);
      run_stream(tests[i]);
      // Error flag still set after the quiet period when expected
      @(negedge clk);
      check_value("err_unaligned", 32'(err_unaligned), 32'(tests[i].misalign));
      if (tests[i].misalign) begin
        apply_reset();
        @(negedge clk);
        check_value("err_unaligned after reset", 32'(err_unaligned), 32'(0));
      end
      $display("Test %0d done: K=%0d, %0d matrices, %0d errors", i, tests[i].k,
               tests[i].mats, error_count - errors_before);
    end

    $display("Tests run: %0d, errors: %0d", NUM_TESTS, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/systolic_array_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_config.svh"

module systolic_array_properties (
  input logic                        clk,
  input logic                        reset,
  input logic [`PE_ROWS-1:0]         left_ready,
  input logic [`PE_COLS-1:0]         top_ready,
  input stream_beat_pkg::psum_beat_t result_beat [`PE_COLS],
  input logic [`PE_COLS-1:0]         result_valid,
  input logic [`PE_COLS-1:0]         result_ready,
  input logic                        err_unaligned
);

  // Registered handshakes are clear one edge into reset
  reset_quiet: assert property (@(posedge clk)
    reset |=> (result_valid == '0 && left_ready == '0 && top_ready == '0))
    else $error("stream handshake active during reset");

  // Sticky flag
  err_sticky: assert property (@(posedge clk) disable iff (reset)
    !$fell(err_unaligned))
    else $error("err_unaligned fell outside reset");

  genvar c;
  generate
    for (c = 0; c < `PE_COLS; c++) begin : g_col
      // Stalled result word waits for its transfer
      result_hold: assert property (@(posedge clk) disable iff (reset)
        (result_valid[c] && !result_ready[c]) |=> result_valid[c])
        else $error("result valid %0d dropped before transfer", c);
      result_stable: assert property (@(posedge clk) disable iff (reset)
        (result_valid[c] && !result_ready[c]) |=> $stable(result_beat[c]))
        else $error("result beat %0d changed while stalled", c);
    end
  endgenerate

endmodule

`default_nettype wire

// File: source/systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_config.svh"

module systolic_array (
  input  logic                          clk,
  input  logic                          reset,
  input  stream_beat_pkg::operand_beat_t left_beat [`PE_ROWS],
  input  logic [`PE_ROWS-1:0]           left_valid,
  output logic [`PE_ROWS-1:0]           left_ready,
  input  stream_beat_pkg::operand_beat_t top_beat [`PE_COLS],
  input  logic [`PE_COLS-1:0]           top_valid,
  output logic [`PE_COLS-1:0]           top_ready,
  output stream_beat_pkg::psum_beat_t    result_beat [`PE_COLS],
  output logic [`PE_COLS-1:0]           result_valid,
  input  logic [`PE_COLS-1:0]           result_ready,
  output logic                          err_unaligned
);
  import stream_beat_pkg::*;

  // Horizontal links, slot c feeds the element in column c
  operand_beat_t h_beat  [`PE_ROWS][`PE_COLS+1];
  logic          h_valid [`PE_ROWS][`PE_COLS+1];
  logic          h_ready [`PE_ROWS][`PE_COLS+1];
  // Vertical operand links, slot r feeds row r
  operand_beat_t v_beat  [`PE_ROWS+1][`PE_COLS];
  logic          v_valid [`PE_ROWS+1][`PE_COLS];
  logic          v_ready [`PE_ROWS+1][`PE_COLS];
  // Result chain, slot r is the up input of row r
  psum_beat_t    d_beat  [`PE_ROWS+1][`PE_COLS];
  logic          d_valid [`PE_ROWS+1][`PE_COLS];
  logic          d_ready [`PE_ROWS+1][`PE_COLS];
  logic [`PE_ROWS*`PE_COLS-1:0] err_vec;

  genvar r, c;
  generate
    for (r = 0; r < `PE_ROWS; r++) begin : g_row_edge
      assign h_beat[r][0]        = left_beat[r];
      assign h_valid[r][0]       = left_valid[r];
      assign left_ready[r]       = h_ready[r][0];
      // Right edge never forwards
      assign h_ready[r][`PE_COLS] = 1'b0;
    end
    for (c = 0; c < `PE_COLS; c++) begin : g_col_edge
      assign v_beat[0][c]         = top_beat[c];
      assign v_valid[0][c]        = top_valid[c];
      assign top_ready[c]         = v_ready[0][c];
      assign v_ready[`PE_ROWS][c] = 1'b0;
      // Nothing above row 0
      assign d_beat[0][c]         = '0;
      assign d_valid[0][c]        = 1'b0;
      // Bottom of the chain is the column output
      assign result_beat[c]       = d_beat[`PE_ROWS][c];
      assign result_valid[c]      = d_valid[`PE_ROWS][c];
      assign d_ready[`PE_ROWS][c] = result_ready[c];
    end

    for (r = 0; r < `PE_ROWS; r++) begin : g_row
      for (c = 0; c < `PE_COLS; c++) begin : g_col
        processing_element #(
          .pe_row (r),
          .pe_col (c)
        ) i_pe (
          .clk           (clk),
          .reset         (reset),
          .left_beat     (h_beat[r][c]),
          .left_valid    (h_valid[r][c]),
          .left_ready    (h_ready[r][c]),
          .top_beat      (v_beat[r][c]),
          .top_valid     (v_valid[r][c]),
          .top_ready     (v_ready[r][c]),
          .up_beat       (d_beat[r][c]),
          .up_valid      (d_valid[r][c]),
          .up_ready      (d_ready[r][c]),
          .right_beat    (h_beat[r][c+1]),
          .right_valid   (h_valid[r][c+1]),
          .right_ready   (h_ready[r][c+1]),
          .bottom_beat   (v_beat[r+1][c]),
          .bottom_valid  (v_valid[r+1][c]),
          .bottom_ready  (v_ready[r+1][c]),
          .down_beat     (d_beat[r+1][c]),
          .down_valid    (d_valid[r+1][c]),
          .down_ready    (d_ready[r+1][c]),
          .err_unaligned (err_vec[r*`PE_COLS+c])
        );
      end
    end
  endgenerate

  // Any element seeing mismatched lasts
  assign err_unaligned = |err_vec;

endmodule

`default_nettype wire

// File: source/processing_element.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_config.svh"

module processing_element #(
  parameter int pe_row    = 0,
  parameter int pe_col    = 0,
  parameter bit has_right = (pe_col < `PE_COLS - 1),
  parameter bit has_below = (pe_row < `PE_ROWS - 1)
) (
  input  logic                          clk,
  input  logic                          reset,

  input  stream_beat_pkg::operand_beat_t left_beat,
  input  logic                          left_valid,
  output logic                          left_ready,

  input  stream_beat_pkg::operand_beat_t top_beat,
  input  logic                          top_valid,
  output logic                          top_ready,

  input  stream_beat_pkg::psum_beat_t    up_beat,
  input  logic                          up_valid,
  output logic                          up_ready,

  output stream_beat_pkg::operand_beat_t right_beat,
  output logic                          right_valid,
  input  logic                          right_ready,

  output stream_beat_pkg::operand_beat_t bottom_beat,
  output logic                          bottom_valid,
  input  logic                          bottom_ready,

  output stream_beat_pkg::psum_beat_t    down_beat,
  output logic                          down_valid,
  input  logic                          down_ready,

  output logic                          err_unaligned
);
  import mm_types_pkg::*;
  import stream_beat_pkg::*;

  localparam bit has_up = (pe_row > 0);

  // Skid buffer sides facing the datapath
  operand_beat_t l_int_beat;
  logic          l_int_valid;
  logic          l_int_ready;
  operand_beat_t t_int_beat;
  logic          t_int_valid;
  logic          t_int_ready;
  psum_beat_t    u_int_beat;
  logic          u_int_valid;
  logic          u_int_ready;
  psum_beat_t    d_int_beat;
  logic          d_int_valid;
  logic          d_int_ready;

  logic  d_last;
  logic  d_from_up;
  logic  acc_enable;
  logic  acc_clear;
  psum_t product;
  psum_t acc_q;

  axis_skid_buffer #(.beat_t(operand_beat_t)) i_left_skid (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (left_beat),
    .in_valid  (left_valid),
    .in_ready  (left_ready),
    .out_beat  (l_int_beat),
    .out_valid (l_int_valid),
    .out_ready (l_int_ready)
  );

  axis_skid_buffer #(.beat_t(operand_beat_t)) i_top_skid (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (top_beat),
    .in_valid  (top_valid),
    .in_ready  (top_ready),
    .out_beat  (t_int_beat),
    .out_valid (t_int_valid),
    .out_ready (t_int_ready)
  );

  generate
    if (has_up) begin : g_up_skid
      axis_skid_buffer #(.beat_t(psum_beat_t)) i_up_skid (
        .clk       (clk),
        .reset     (reset),
        .in_beat   (up_beat),
        .in_valid  (up_valid),
        .in_ready  (up_ready),
        .out_beat  (u_int_beat),
        .out_valid (u_int_valid),
        .out_ready (u_int_ready)
      );
    end else begin : g_no_up
      // Top row, nothing arrives from above
      assign up_ready    = 1'b0;
      assign u_int_beat  = '0;
      assign u_int_valid = 1'b0;
    end
  endgenerate

  axis_skid_buffer #(.beat_t(psum_beat_t)) i_down_skid (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (d_int_beat),
    .in_valid  (d_int_valid),
    .in_ready  (d_int_ready),
    .out_beat  (down_beat),
    .out_valid (down_valid),
    .out_ready (down_ready)
  );

  pe_control #(
    .has_up    (has_up),
    .has_right (has_right),
    .has_below (has_below)
  ) i_pe_control (
    .clk           (clk),
    .reset         (reset),
    .l_valid       (l_int_valid),
    .l_last        (l_int_beat.last),
    .t_valid       (t_int_valid),
    .t_last        (t_int_beat.last),
    .u_valid       (u_int_valid),
    .u_last        (u_int_beat.last),
    .r_ready       (right_ready),
    .b_ready       (bottom_ready),
    .d_ready       (d_int_ready),
    .l_ready       (l_int_ready),
    .t_ready       (t_int_ready),
    .u_ready       (u_int_ready),
    .r_valid       (right_valid),
    .b_valid       (bottom_valid),
    .d_valid       (d_int_valid),
    .d_last        (d_last),
    .d_from_up     (d_from_up),
    .acc_enable    (acc_enable),
    .acc_clear     (acc_clear),
    .err_unaligned (err_unaligned)
  );

  // Operands travel on unchanged, valids come from control
  assign right_beat  = l_int_beat;
  assign bottom_beat = t_int_beat;

  // Full signed product fits the sum width
  assign product = psum_t'(l_int_beat.data) * psum_t'(t_int_beat.data);

  // MAC register, first pair of a vector overwrites
  always_ff @(posedge clk) begin
    if (acc_enable) begin
      acc_q <= acc_clear ? product : acc_q + product;
    end
  end

  // Own result or a word passed from above
  always_comb begin
    d_int_beat.data = d_from_up ? u_int_beat.data : acc_q;
    d_int_beat.last = d_last;
  end

endmodule

`default_nettype wire

// File: source/pe_control.sv
`timescale 1ns/1ps
`default_nettype none

module pe_control #(
  parameter bit has_up    = 1'b0,
  parameter bit has_right = 1'b0,
  parameter bit has_below = 1'b0
) (
  input  logic clk,
  input  logic reset,
  input  logic l_valid,
  input  logic l_last,
  input  logic t_valid,
  input  logic t_last,
  input  logic u_valid,
  input  logic u_last,
  input  logic r_ready,
  input  logic b_ready,
  input  logic d_ready,
  output logic l_ready,
  output logic t_ready,
  output logic u_ready,
  output logic r_valid,
  output logic b_valid,
  output logic d_valid,
  output logic d_last,
  output logic d_from_up,
  output logic acc_enable,
  output logic acc_clear,
  output logic err_unaligned
);
  import mm_types_pkg::*;

  pe_state_t state_q;
  pe_state_t state_d;
  // Next fire starts a new vector
  logic      first_q;
  logic      pair_ok;
  logic      right_ok;
  logic      below_ok;
  logic      fire;
  logic      vec_end;

  // Both operands present while accumulating
  assign pair_ok  = (state_q == ST_ACCUM) && l_valid && t_valid;
  // Edge elements have no neighbour to wait on
  assign right_ok = !has_right || r_ready;
  assign below_ok = !has_below || b_ready;
  assign fire     = pair_ok && right_ok && below_ok;
  assign vec_end  = fire && (l_last || t_last);

  // Copy valids wait only on the other copy
  // so each transfer lines up with fire
  assign r_valid = has_right && pair_ok && below_ok;
  assign b_valid = has_below && pair_ok && right_ok;

  // Left and top consumed together
  assign l_ready = fire;
  assign t_ready = fire;

  assign acc_enable = fire;
  assign acc_clear  = first_q;

  // Down stream source and flags
  assign d_from_up = (state_q == ST_FORWARD_UP);
  assign d_valid   = (state_q == ST_EXPORT) || (d_from_up && u_valid);
  assign u_ready   = d_from_up && d_ready;
  // Only row 0 closes the column with its own word
  assign d_last    = (state_q == ST_EXPORT) ? !has_up : (d_from_up && u_last);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_ACCUM: begin
        if (vec_end) begin
          state_d = ST_EXPORT;
        end
      end
      ST_EXPORT: begin
        if (d_ready) begin
          state_d = has_up ? ST_FORWARD_UP : ST_ACCUM;
        end
      end
      ST_FORWARD_UP: begin
        // Back to work after the closing word from above
        if (u_valid && d_ready && u_last) begin
          state_d = ST_ACCUM;
        end
      end
      default: state_d = ST_ACCUM;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q       <= ST_ACCUM;
      first_q       <= 1'b1;
      err_unaligned <= 1'b0;
    end else begin
      state_q <= state_d;
      if (fire) begin
        first_q <= l_last || t_last;
      end
      // Sticky, the vector still ends on either last
      if (fire && (l_last != t_last)) begin
        err_unaligned <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/axis_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer #(
  parameter type beat_t = logic
) (
  input  logic  clk,
  input  logic  reset,

  input  beat_t in_beat,
  input  logic  in_valid,
  output logic  in_ready,

  output beat_t out_beat,
  output logic  out_valid,
  input  logic  out_ready
);

  // Second entry, only filled while the output stalls
  beat_t skid_beat;
  logic  skid_valid;
  logic  skid_valid_d;
  // Main register can take a beat this cycle
  logic  main_free;
  logic  in_fire;

  assign main_free = !out_valid || out_ready;
  assign in_fire   = in_valid && in_ready;

  // Skid empties whenever the main register moves
  always_comb begin
    if (main_free) begin
      skid_valid_d = 1'b0;
    end else begin
      skid_valid_d = skid_valid || in_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      if (main_free) begin
        out_valid <= skid_valid || in_fire;
      end
      skid_valid <= skid_valid_d;
      // Registered ready, low only with both entries full
      in_ready   <= !skid_valid_d;
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (main_free) begin
      // Older beat in the skid goes first
      out_beat <= skid_valid ? skid_beat : in_beat;
    end
    if (!main_free && in_fire) begin
      skid_beat <= in_beat;
    end
  end

endmodule

`default_nettype wire

// File: source/stream_beat_pkg.sv
`default_nettype none

package stream_beat_pkg;

  // Left and top operand beat
  // Data in the upper bits, last in bit 0
  typedef struct packed {
    mm_types_pkg::operand_t data;
    logic                   last;
  } operand_beat_t;

  // Partial sum beat on the up and down chain
  typedef struct packed {
    mm_types_pkg::psum_t data;
    logic                last;
  } psum_beat_t;

  // Last marks the end of a vector on operand streams
  // and the end of a column on result streams

endpackage

`default_nettype wire

// File: source/mm_types_pkg.sv
`default_nettype none

`include "pe_config.svh"

package mm_types_pkg;

  // Operand on the left and top streams
  typedef logic signed [`PE_OPERAND_WIDTH-1:0] operand_t;

  // Accumulator, product and result word
  typedef logic signed [`PE_PSUM_WIDTH-1:0] psum_t;

  // Element control states
  typedef enum logic [1:0] {
    // Taking operand pairs
    ST_ACCUM,
    // Own result on the down stream
    ST_EXPORT,
    // Passing results from the element above
    ST_FORWARD_UP
  } pe_state_t;

endpackage

`default_nettype wire

// File: source/pe_config.svh
`ifndef PE_CONFIG_SVH
`define PE_CONFIG_SVH

// Signed operand width on the left and top streams
`define PE_OPERAND_WIDTH 16

// Accumulator and result width
// Wide enough for one full 16x16 product
`define PE_PSUM_WIDTH 32

// Grid size
`define PE_ROWS 2
`define PE_COLS 2

// Products and sums wrap modulo 2^PE_PSUM_WIDTH

`endif
